/* tb.f */
afu_pkg.sv
queue_conf_regs.sv
line_fifo.sv
input_queue_controller.sv
output_queue_controller.sv
afu_user.sv
dsm_controller.sv
afu_top.sv
tb_clock_gen.sv
afu_assertions.sv
afu_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the AFU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module afu_tb

out=$(./obj_dir/Vafu_tb +verilator+error+limit+1000)
echo "$out"

if echo "$out" | grep -qx "TESTS PASSED"; then
  exit 0
fi
exit 1

/* afu_tb.sv */
`timescale 1ns/1ps

module afu_tb;

  localparam int AFU_ID          = 5;
  localparam int TOTAL_LINES     = 8 + 20 + 6 + 12;
  localparam int WATCHDOG_CYCLES = 200 * TOTAL_LINES + 2000;

  localparam afu_pkg::tag_t IN_TAG  = 8'd3;
  localparam afu_pkg::tag_t OUT_TAG = 8'd7;

  logic                       clk;
  logic                       arst_n;
  logic                       start;
  logic [1:0]                 conf_valid;
  logic [afu_pkg::CONF_W-1:0] conf;
  logic                       available_read;
  logic                       request_read;
  afu_pkg::req_t              request_data;
  logic                       read_data_valid;
  afu_pkg::tag_t              read_queue_id;
  afu_pkg::line_t             read_data;
  logic                       available_write;
  logic                       request_write;
  afu_pkg::wreq_t             write_data;
  logic                       write_data_valid;
  afu_pkg::tag_t              write_queue_id;
  logic                       status_valid;
  afu_pkg::status_t           status_data;

  // host side logs, cleared before every run
  afu_pkg::addr_t   rd_addrs[$];
  afu_pkg::tag_t    rd_tags[$];
  afu_pkg::line_t   rd_lines[$];
  afu_pkg::line_t   wr_lines[$];
  afu_pkg::addr_t   wr_addrs[$];
  afu_pkg::tag_t    wr_tags[$];
  int               rd_due[$];
  afu_pkg::tag_t    rd_ret_tag[$];
  int               wr_due[$];
  afu_pkg::tag_t    wr_ack_tag[$];
  int               cyc = 0;
  int               last_rd_due = 0;
  int               last_wr_due = 0;
  int               acks_sent = 0;
  int               acks_at_status = 0;
  int               status_seen = 0;
  afu_pkg::status_t status_word;
  bit               toggle_avail = 1'b0;
  int               foreign_rd = 0;
  int               foreign_ack = 0;
  int               value_errors = 0;
  int               other_errors = 0;
  logic [31:0]      rng_state = 32'd53;

  tb_clock_gen #(
    .PERIOD_NS    (40),
    .RESET_CYCLES (16)
  ) clock_gen (
    .clk    (clk),
    .arst_n (arst_n)
  );

  afu_top #(
    .FIFO_DEPTH_BITS (2),
    .AFU_ID          (AFU_ID)
  ) u_dut (
    .clk              (clk),
    .arst_n           (arst_n),
    .start            (start),
    .conf_valid       (conf_valid),
    .conf             (conf),
    .available_read   (available_read),
    .request_read     (request_read),
    .request_data     (request_data),
    .read_data_valid  (read_data_valid),
    .read_queue_id    (read_queue_id),
    .read_data        (read_data),
    .available_write  (available_write),
    .request_write    (request_write),
    .write_data       (write_data),
    .write_data_valid (write_data_valid),
    .write_queue_id   (write_queue_id),
    .status_valid     (status_valid),
    .status_data      (status_data)
  );

  bind afu_top afu_assertions u_afu_assertions (
    .clk             (clk),
    .arst_n          (arst_n),
    .available_read  (available_read),
    .request_read    (request_read),
    .available_write (available_write),
    .request_write   (request_write),
    .status_valid    (status_valid)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  task automatic check_line(input string name, input afu_pkg::line_t exp,
                            input afu_pkg::line_t act);
    if (act !== exp) begin
      value_errors++;
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_addr(input string name, input afu_pkg::addr_t exp,
                            input afu_pkg::addr_t act);
    if (act !== exp) begin
      value_errors++;
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_tag(input string name, input afu_pkg::tag_t exp,
                           input afu_pkg::tag_t act);
    if (act !== exp) begin
      value_errors++;
      $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input afu_pkg::qtd_t exp,
                             input afu_pkg::qtd_t act);
    if (act !== exp) begin
      value_errors++;
      $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_status(input string name, input afu_pkg::status_t exp,
                              input afu_pkg::status_t act);
    if (act !== exp) begin
      value_errors++;
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // host monitor, sees the DUT outputs as they stand at the rising edge
  always @(posedge clk) begin : host_monitor
    int due;
    cyc = cyc + 1;
    if (request_read) begin
      rd_addrs.push_back(request_data.addr);
      rd_tags.push_back(request_data.tag);
      due = cyc + 1 + int'(next_random() & 32'h3);
      if (due <= last_rd_due) due = last_rd_due + 1;  // data comes back in request order
      last_rd_due = due;
      rd_due.push_back(due);
      rd_ret_tag.push_back(request_data.tag);
    end
    if (request_write) begin
      wr_lines.push_back(write_data.line);
      wr_addrs.push_back(write_data.addr);
      wr_tags.push_back(write_data.tag);
      due = cyc + 1 + int'(next_random() % 32'd3);
      if (due <= last_wr_due) due = last_wr_due + 1;
      last_wr_due = due;
      wr_due.push_back(due);
      wr_ack_tag.push_back(write_data.tag);
    end
    if (status_valid) begin
      status_seen++;
      status_word    = status_data;
      acks_at_status = acks_sent;
    end
  end

  // host driver, everything it touches changes on the falling edge
  initial begin : host_model
    logic [31:0]    r;
    logic [31:0]    hi;
    logic [31:0]    lo;
    available_read   = 1'b1;
    available_write  = 1'b1;
    read_data_valid  = 1'b0;
    read_queue_id    = '0;
    read_data        = '0;
    write_data_valid = 1'b0;
    write_queue_id   = '0;
    forever begin
      @(negedge clk);
      if (toggle_avail) begin
        r = next_random();
        available_read  = r[0] | r[1];
        available_write = r[2] | r[3];
      end else begin
        available_read  = 1'b1;
        available_write = 1'b1;
      end
      read_data_valid = 1'b0;
      if (rd_due.size() > 0 && rd_due[0] <= cyc) begin
        hi = next_random();
        lo = next_random();
        void'(rd_due.pop_front());
        read_data_valid = 1'b1;
        read_queue_id   = rd_ret_tag.pop_front();
        read_data       = {hi, lo};
        rd_lines.push_back({hi, lo});
      end else if (foreign_rd > 0) begin
        read_data_valid = 1'b1;
        read_queue_id   = OUT_TAG;  // belongs to the other queue
        read_data       = {next_random(), 32'hdead_beef};
        foreign_rd--;
      end
      write_data_valid = 1'b0;
      if (wr_due.size() > 0 && wr_due[0] <= cyc) begin
        void'(wr_due.pop_front());
        write_data_valid = 1'b1;
        write_queue_id   = wr_ack_tag.pop_front();
        acks_sent++;
      end else if (foreign_ack > 0) begin
        write_data_valid = 1'b1;
        write_queue_id   = IN_TAG;
        foreign_ack--;
      end
    end
  end

  task automatic configure_queue(input int sel, input afu_pkg::addr_t base,
                                 input afu_pkg::qtd_t count, input afu_pkg::tag_t tag);
    conf_valid      = '0;
    conf_valid[sel] = 1'b1;
    conf            = {base, count, tag};
    @(negedge clk);
    conf_valid = '0;
  endtask

  task automatic pulse_start();
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
  endtask

  task automatic run_and_check(input string name, input afu_pkg::addr_t in_base,
                               input afu_pkg::addr_t out_base, input afu_pkg::qtd_t count,
                               input bit shake, input int foreign_beats);
    afu_pkg::line_t   prev;
    afu_pkg::status_t exp_status;
    int               limit;
    int               waited;
    rd_addrs.delete();
    rd_tags.delete();
    rd_lines.delete();
    wr_lines.delete();
    wr_addrs.delete();
    wr_tags.delete();
    status_seen  = 0;
    acks_sent    = 0;
    toggle_avail = shake;
    foreign_rd   = foreign_beats;
    foreign_ack  = foreign_beats;
    configure_queue(afu_pkg::CONF_IN, in_base, count, IN_TAG);
    configure_queue(afu_pkg::CONF_OUT, out_base, count, OUT_TAG);
    pulse_start();
    limit  = 200 * int'(count) + 200;
    waited = 0;
    while (status_seen == 0 && waited < limit) begin
      @(negedge clk);
      waited++;
    end
    if (status_seen == 0) begin
      other_errors++;
      $display("%s: no status word arrived within %0d cycles", name, limit);
    end
    repeat (20) @(negedge clk);  // a second status pulse would show up here
    toggle_avail = 1'b0;

    check_count({name, " read requests"}, count, afu_pkg::qtd_t'(rd_addrs.size()));
    foreach (rd_addrs[i]) begin
      check_addr({name, " read address"}, in_base + afu_pkg::addr_t'(i), rd_addrs[i]);
      check_tag({name, " read tag"}, IN_TAG, rd_tags[i]);
    end
    check_count({name, " write requests"}, count, afu_pkg::qtd_t'(wr_lines.size()));
    prev = '0;
    foreach (wr_lines[i]) begin
      if (i < rd_lines.size()) begin
        check_line({name, " write line"}, rd_lines[i] ^ prev, wr_lines[i]);
        prev = rd_lines[i];
      end
      check_addr({name, " write address"}, out_base + afu_pkg::addr_t'(i), wr_addrs[i]);
      check_tag({name, " write tag"}, OUT_TAG, wr_tags[i]);
    end
    check_count({name, " status pulses"}, 16'd1, afu_pkg::qtd_t'(status_seen));
    check_count({name, " acks before status"}, count, afu_pkg::qtd_t'(acks_at_status));

    exp_status               = '0;
    exp_status.afu_id        = afu_pkg::afu_id_t'(AFU_ID);
    exp_status.lines_read    = count;
    exp_status.lines_written = count;
    exp_status.acks          = count[afu_pkg::QTD_W-2:0];
    exp_status.done          = 1'b1;
    check_status({name, " status word"}, exp_status, status_word);
  endtask

  task automatic basic_run();
    run_and_check("basic_run", 32'h0000_1000, 32'h0000_8000, 16'd8, 1'b0, 0);
  endtask

  task automatic back_pressure_run();
    run_and_check("back_pressure", 32'h0002_0000, 32'h0003_0000, 16'd20, 1'b1, 0);
  endtask

  // wrong-tag beats go in early, while the real traffic is running
  task automatic foreign_tag_run();
    run_and_check("foreign_tags", 32'h0000_4000, 32'h0000_5000, 16'd6, 1'b0, 5);
  endtask

  task automatic reconfiguration_run();
    run_and_check("reconfiguration", 32'h00a0_0100, 32'h00b0_0200, 16'd12, 1'b0, 0);
  endtask

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin : main
    int assert_fails;
    start      = 1'b0;
    conf_valid = '0;
    conf       = '0;
    wait (arst_n === 1'b1);
    @(negedge clk);
    basic_run();
    back_pressure_run();
    foreign_tag_run();
    reconfiguration_run();
    assert_fails = int'(u_dut.u_afu_assertions.fail_count);
    $display("summary: %0d value errors, %0d other errors, %0d assertion failures",
             value_errors, other_errors, assert_fails);
    if (value_errors + other_errors + assert_fails == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* afu_assertions.sv */
`timescale 1ns/1ps

module afu_assertions (
  input logic clk,
  input logic arst_n,
  input logic available_read,
  input logic request_read,
  input logic available_write,
  input logic request_write,
  input logic status_valid
);

  int unsigned fail_count = 0;

  read_needs_avail: assert property (@(posedge clk) disable iff (!arst_n)
      request_read |-> available_read)
    else begin
      fail_count++;
      $error("request_read pulsed while available_read was low");
    end

  write_needs_avail: assert property (@(posedge clk) disable iff (!arst_n)
      request_write |-> available_write)
    else begin
      fail_count++;
      $error("request_write pulsed while available_write was low");
    end

  // a status word is a single-cycle strobe
  status_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
      status_valid |=> !status_valid)
    else begin
      fail_count++;
      $error("status_valid stayed high for more than one cycle");
    end

  quiet_in_reset: assert property (@(posedge clk)
      !arst_n |-> !(request_read || request_write || status_valid))
    else begin
      fail_count++;
      $error("request or status strobe seen while reset was asserted");
    end

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 16
) (
  output logic clk,
  output logic arst_n
);

  initial clk = 1'b0;
  always #(PERIOD_NS / 2) clk = ~clk;

  initial begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;  // released away from the active edge
  end

endmodule

/* afu_top.sv */
`timescale 1ns/1ps

module afu_top #(
  parameter int FIFO_DEPTH_BITS = 2,
  parameter int AFU_ID          = 5
) (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       start,
  input  logic [1:0]                 conf_valid,
  input  logic [afu_pkg::CONF_W-1:0] conf,
  input  logic                       available_read,
  output logic                       request_read,
  output afu_pkg::req_t              request_data,
  input  logic                       read_data_valid,
  input  afu_pkg::tag_t              read_queue_id,
  input  afu_pkg::line_t             read_data,
  input  logic                       available_write,
  output logic                       request_write,
  output afu_pkg::wreq_t             write_data,
  input  logic                       write_data_valid,
  input  afu_pkg::tag_t              write_queue_id,
  output logic                       status_valid,
  output afu_pkg::status_t           status_data
);

  afu_pkg::addr_t in_base;
  afu_pkg::qtd_t  in_count;
  afu_pkg::tag_t  in_tag;
  afu_pkg::addr_t out_base;
  afu_pkg::qtd_t  out_count;
  afu_pkg::tag_t  out_tag;
  logic           in_avail;
  logic           in_pop;
  afu_pkg::line_t in_line;
  logic           out_avail;
  logic           out_push;
  afu_pkg::line_t out_line;
  afu_pkg::qtd_t  lines_read;
  afu_pkg::qtd_t  lines_written;
  afu_pkg::qtd_t  acks;
  logic           done_rd;
  logic           done_wr;
  logic           pending;
  logic           user_done;

  queue_conf_regs queue_conf_regs (
    .clk        (clk),
    .arst_n     (arst_n),
    .conf_valid (conf_valid),
    .conf       (conf),
    .in_base    (in_base),
    .in_count   (in_count),
    .in_tag     (in_tag),
    .out_base   (out_base),
    .out_count  (out_count),
    .out_tag    (out_tag)
  );

  input_queue_controller #(
    .FIFO_DEPTH_BITS (FIFO_DEPTH_BITS)
  ) input_queue_controller (
    .clk             (clk),
    .arst_n          (arst_n),
    .start           (start),
    .base            (in_base),
    .count           (in_count),
    .tag             (in_tag),
    .available_read  (available_read),
    .request_read    (request_read),
    .request_data    (request_data),
    .read_data_valid (read_data_valid),
    .read_queue_id   (read_queue_id),
    .read_data       (read_data),
    .in_avail        (in_avail),
    .in_pop          (in_pop),
    .in_line         (in_line),
    .lines_read      (lines_read),
    .done            (done_rd)
  );

  afu_user afu_user (
    .clk       (clk),
    .arst_n    (arst_n),
    .start     (start),
    .in_avail  (in_avail),
    .in_pop    (in_pop),
    .in_line   (in_line),
    .out_avail (out_avail),
    .out_push  (out_push),
    .out_line  (out_line),
    .count     (in_count),
    .user_done (user_done)
  );

  output_queue_controller #(
    .FIFO_DEPTH_BITS (FIFO_DEPTH_BITS)
  ) output_queue_controller (
    .clk              (clk),
    .arst_n           (arst_n),
    .start            (start),
    .base             (out_base),
    .count            (out_count),
    .tag              (out_tag),
    .out_avail        (out_avail),
    .out_push         (out_push),
    .out_line         (out_line),
    .available_write  (available_write),
    .request_write    (request_write),
    .write_data       (write_data),
    .write_data_valid (write_data_valid),
    .write_queue_id   (write_queue_id),
    .lines_written    (lines_written),
    .acks             (acks),
    .pending          (pending),
    .done             (done_wr)
  );

  dsm_controller #(
    .AFU_ID (AFU_ID)
  ) dsm_controller (
    .clk           (clk),
    .arst_n        (arst_n),
    .start         (start),
    .done_rd       (done_rd),
    .done_wr       (done_wr),
    .user_done     (user_done),
    .pending       (pending),
    .lines_read    (lines_read),
    .lines_written (lines_written),
    .acks          (acks),
    .status_valid  (status_valid),
    .status_data   (status_data)
  );

endmodule

/* dsm_controller.sv */
`timescale 1ns/1ps

module dsm_controller #(
  parameter int AFU_ID = 5
) (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             start,
  input  logic             done_rd,
  input  logic             done_wr,
  input  logic             user_done,
  input  logic             pending,
  input  afu_pkg::qtd_t    lines_read,
  input  afu_pkg::qtd_t    lines_written,
  input  afu_pkg::qtd_t    acks,
  output logic             status_valid,
  output afu_pkg::status_t status_data
);

  logic armed;
  logic fire;

  // counters are cleared on the start edge, so nothing is checked in that cycle
  assign fire = armed && !start && done_rd && done_wr && user_done && !pending;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      armed        <= 1'b0;
      status_valid <= 1'b0;
    end else begin
      status_valid <= fire;
      if (start) armed <= 1'b1;
      else if (fire) armed <= 1'b0;  // one status word per run
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      status_data.afu_id        <= afu_pkg::afu_id_t'(AFU_ID);
      status_data.reserved      <= '0;
      status_data.lines_read    <= lines_read;
      status_data.lines_written <= lines_written;
      status_data.acks          <= acks[afu_pkg::QTD_W-2:0];
      status_data.done          <= 1'b1;
    end
  end

endmodule

/* afu_user.sv */
`timescale 1ns/1ps

module afu_user (
  input  logic           clk,
  input  logic           arst_n,
  input  logic           start,
  input  logic           in_avail,
  output logic           in_pop,
  input  afu_pkg::line_t in_line,
  input  logic           out_avail,
  output logic           out_push,
  output afu_pkg::line_t out_line,
  input  afu_pkg::qtd_t  count,
  output logic           user_done
);

  afu_pkg::line_t prev_line;
  afu_pkg::qtd_t  processed;

  // a line moves only when there is room for its delta on the output side
  assign in_pop    = in_avail && out_avail;
  assign out_push  = in_pop;
  assign out_line  = in_line ^ prev_line;
  assign user_done = (processed == count);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      prev_line <= '0;
      processed <= '0;
    end else if (start) begin
      prev_line <= '0;  // the delta chain restarts from zero on every run
      processed <= '0;
    end else if (in_pop) begin
      prev_line <= in_line;
      processed <= processed + 1'b1;
    end
  end

endmodule

/* output_queue_controller.sv */
`timescale 1ns/1ps

module output_queue_controller #(
  parameter int FIFO_DEPTH_BITS = 2
) (
  input  logic           clk,
  input  logic           arst_n,
  input  logic           start,
  input  afu_pkg::addr_t base,
  input  afu_pkg::qtd_t  count,
  input  afu_pkg::tag_t  tag,
  output logic           out_avail,
  input  logic           out_push,
  input  afu_pkg::line_t out_line,
  input  logic           available_write,
  output logic           request_write,
  output afu_pkg::wreq_t write_data,
  input  logic           write_data_valid,
  input  afu_pkg::tag_t  write_queue_id,
  output afu_pkg::qtd_t  lines_written,
  output afu_pkg::qtd_t  acks,
  output logic           pending,
  output logic           done
);

  logic           fifo_empty;
  logic           fifo_full;
  logic           fifo_pop;
  afu_pkg::line_t head_line;
  logic           wr_valid;  // a line sits in the request register
  afu_pkg::line_t wr_line;

  assign out_avail     = !fifo_full;
  assign request_write = wr_valid && available_write;
  assign fifo_pop      = !fifo_empty && (!wr_valid || request_write);

  assign write_data.line = wr_line;
  assign write_data.addr = base + afu_pkg::addr_t'(lines_written);
  assign write_data.tag  = tag;

  assign pending = (lines_written > acks);
  assign done    = (acks == count);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_valid      <= 1'b0;
      lines_written <= '0;
      acks          <= '0;
    end else begin
      if (fifo_pop) wr_valid <= 1'b1;
      else if (request_write) wr_valid <= 1'b0;
      if (start) begin
        lines_written <= '0;
        acks          <= '0;
      end else begin
        if (request_write) lines_written <= lines_written + 1'b1;
        if (write_data_valid && (write_queue_id == tag)) acks <= acks + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fifo_pop) wr_line <= head_line;
  end

  line_fifo #(
    .payload_t  (afu_pkg::line_t),
    .DEPTH_BITS (FIFO_DEPTH_BITS)
  ) out_fifo (
    .clk       (clk),
    .arst_n    (arst_n),
    .push      (out_push),
    .push_data (out_line),
    .pop       (fifo_pop),
    .pop_data  (head_line),
    .empty     (fifo_empty),
    .full      (fifo_full),
    .level     ()
  );

endmodule

/* input_queue_controller.sv */
`timescale 1ns/1ps

module input_queue_controller #(
  parameter int FIFO_DEPTH_BITS = 2
) (
  input  logic           clk,
  input  logic           arst_n,
  input  logic           start,
  input  afu_pkg::addr_t base,
  input  afu_pkg::qtd_t  count,
  input  afu_pkg::tag_t  tag,
  input  logic           available_read,
  output logic           request_read,
  output afu_pkg::req_t  request_data,
  input  logic           read_data_valid,
  input  afu_pkg::tag_t  read_queue_id,
  input  afu_pkg::line_t read_data,
  output logic           in_avail,
  input  logic           in_pop,
  output afu_pkg::line_t in_line,
  output afu_pkg::qtd_t  lines_read,
  output logic           done
);

  localparam logic [FIFO_DEPTH_BITS+1:0] DEPTH = 1 << FIFO_DEPTH_BITS;

  logic                     running;
  afu_pkg::qtd_t            issued;
  logic [FIFO_DEPTH_BITS:0] outstanding;  // requested lines not yet in the fifo
  logic [FIFO_DEPTH_BITS:0] level;
  logic [FIFO_DEPTH_BITS+1:0] used;
  logic                     fifo_empty;
  logic                     tag_hit;
  logic                     push_q;
  afu_pkg::line_t           push_line;

  // a slot is reserved in the fifo for every read still in flight
  assign used         = {1'b0, level} + {1'b0, outstanding};
  assign request_read = running && (issued < count) && available_read && (used < DEPTH);

  assign request_data.addr = base + afu_pkg::addr_t'(issued);
  assign request_data.tag  = tag;

  assign tag_hit  = read_data_valid && (read_queue_id == tag);  // other queues' data is dropped
  assign in_avail = !fifo_empty;
  assign done     = (lines_read == count);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      running     <= 1'b0;
      issued      <= '0;
      outstanding <= '0;
      lines_read  <= '0;
      push_q      <= 1'b0;
    end else begin
      push_q <= tag_hit;
      if (start) begin
        running     <= 1'b1;
        issued      <= '0;
        outstanding <= '0;
        lines_read  <= '0;
      end else begin
        if (issued == count) running <= 1'b0;  // all requests out, wait for next start
        if (request_read) issued <= issued + 1'b1;
        if (push_q) lines_read <= lines_read + 1'b1;
        case ({request_read, push_q})
          2'b10:   outstanding <= outstanding + 1'b1;
          2'b01:   outstanding <= outstanding - 1'b1;
          default: outstanding <= outstanding;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (tag_hit) push_line <= read_data;
  end

  line_fifo #(
    .payload_t  (afu_pkg::line_t),
    .DEPTH_BITS (FIFO_DEPTH_BITS)
  ) in_fifo (
    .clk       (clk),
    .arst_n    (arst_n),
    .push      (push_q),
    .push_data (push_line),
    .pop       (in_pop),
    .pop_data  (in_line),
    .empty     (fifo_empty),
    .full      (),
    .level     (level)
  );

endmodule

/* line_fifo.sv */
`timescale 1ns/1ps

module line_fifo #(
  parameter type payload_t  = logic [31:0],
  parameter int  DEPTH_BITS = 2
) (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                push,
  input  payload_t            push_data,
  input  logic                pop,
  output payload_t            pop_data,
  output logic                empty,
  output logic                full,
  output logic [DEPTH_BITS:0] level
);

  localparam int DEPTH = 2 ** DEPTH_BITS;

  payload_t              mem [DEPTH];
  logic [DEPTH_BITS-1:0] wr_ptr;
  logic [DEPTH_BITS-1:0] rd_ptr;
  logic                  do_push;
  logic                  do_pop;

  assign empty    = (level == '0);
  assign full     = level[DEPTH_BITS];  // level never goes past DEPTH
  assign do_push  = push && !full;
  assign do_pop   = pop && !empty;
  assign pop_data = mem[rd_ptr];  // head is visible before the pop

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= push_data;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop) rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: level <= level;
      endcase
    end
  end

endmodule

/* queue_conf_regs.sv */
`timescale 1ns/1ps

module queue_conf_regs (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic [1:0]                 conf_valid,
  input  logic [afu_pkg::CONF_W-1:0] conf,
  output afu_pkg::addr_t             in_base,
  output afu_pkg::qtd_t              in_count,
  output afu_pkg::tag_t              in_tag,
  output afu_pkg::addr_t             out_base,
  output afu_pkg::qtd_t              out_count,
  output afu_pkg::tag_t              out_tag
);

  afu_pkg::conf_t desc;

  assign desc = afu_pkg::conf_t'(conf);  // splits the bus into its three fields

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      in_base   <= '0;
      in_count  <= '0;
      in_tag    <= '0;
      out_base  <= '0;
      out_count <= '0;
      out_tag   <= '0;
    end else begin
      // each queue keeps its descriptor until its own bit comes again
      if (conf_valid[afu_pkg::CONF_IN]) begin
        in_base  <= desc.base;
        in_count <= desc.count;
        in_tag   <= desc.tag;
      end
      if (conf_valid[afu_pkg::CONF_OUT]) begin
        out_base  <= desc.base;
        out_count <= desc.count;
        out_tag   <= desc.tag;
      end
    end
  end

endmodule

/* afu_pkg.sv */
package afu_pkg;

  localparam int ADDR_W = 32;
  localparam int LINE_W = 64;
  localparam int TAG_W  = 8;
  localparam int QTD_W  = 16;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [LINE_W-1:0] line_t;
  typedef logic [TAG_W-1:0]  tag_t;
  typedef logic [QTD_W-1:0]  qtd_t;

  // base address sits in the top bits of conf, the queue tag at the bottom
  localparam int CONF_W = ADDR_W + QTD_W + TAG_W;

  typedef struct packed {
    addr_t base;
    qtd_t  count;
    tag_t  tag;
  } conf_t;

  localparam int CONF_IN  = 0;  // conf_valid bit that loads the input queue
  localparam int CONF_OUT = 1;

  typedef struct packed {
    addr_t addr;
    tag_t  tag;
  } req_t;

  typedef struct packed {
    line_t line;
    addr_t addr;
    tag_t  tag;
  } wreq_t;

  localparam int STATUS_W = 64;
  localparam int ID_W     = 8;
  localparam int RSVD_W   = STATUS_W - ID_W - 3 * QTD_W;

  typedef logic [ID_W-1:0] afu_id_t;

  // ack count loses its top bit to make room for the done flag
  typedef struct packed {
    afu_id_t           afu_id;
    logic [RSVD_W-1:0] reserved;
    qtd_t              lines_read;
    qtd_t              lines_written;
    logic [QTD_W-2:0]  acks;
    logic              done;
  } status_t;

endpackage
